// ==== verilog.f ====
rtl/lsu_pkg.sv
rtl/lsu_access_fsm.sv
rtl/lsu_store_path.sv
rtl/lsu_load_path.sv
rtl/lsu_top.sv
verif/lsu_checker.sv
verif/tb_lsu.sv

// ==== Bender.yml ====
package:
  name: lsu

sources:
  - files:
      - rtl/lsu_pkg.sv
      - rtl/lsu_access_fsm.sv
      - rtl/lsu_store_path.sv
      - rtl/lsu_load_path.sv
      - rtl/lsu_top.sv
  - target: simulation
    files:
      - verif/lsu_checker.sv
      - verif/tb_lsu.sv

// ==== verif/tb_lsu.sv ====
// Testbench for the load/store unit. Runs a sweep over kind, address
// space, width and offset, then random accesses, against small word-array
// models of main memory and the register space with random read latency.

module tb_lsu;

    import lsu_pkg::*;

    localparam int reg_bits        = 8;
    localparam int random_accesses = 120;
    localparam int wait_limit      = 20;

    logic                      clk;
    logic                      reset_n;
    logic                      access_enable;
    logic                      load_active;
    logic                      store_active;
    ls_width_t                 width;
    logic [xlen-1:0]           write_addr;
    logic [xlen-1:0]           read_addr;
    logic [xlen-1:0]           store_data;
    logic [reg_addr_bits-1:0]  rd_addr;
    logic                      mem_valid;
    logic [xlen-1:0]           mem_rdata;
    logic                      mm_reg_valid;
    logic [xlen-1:0]           mm_reg_rdata;
    logic                      mem_re;
    logic [xlen_bytes-1:0]     mem_we;
    logic [xlen-1:0]           mem_wdata;
    logic [xlen-1:0]           mem_addr;
    logic                      mm_reg_re;
    logic [xlen_bytes-1:0]     mm_reg_we;
    logic [xlen-1:0]           mm_reg_wdata;
    logic [reg_bits-1:0]       mm_reg_addr;
    logic                      store_done;
    logic                      load_done;
    logic                      exception_alignment;
    logic                      reg_we;
    logic [reg_addr_bits-1:0]  reg_addr;
    logic [xlen-1:0]           reg_wdata;
    int                        mismatch_count;
    int                        check_count;
    int                        timeout_count;
    int                        resp_delay;
    logic [31:0]               seed;
    logic [31:0]               mem_model [16];
    logic [31:0]               reg_model [16];
    ls_width_t                 widths [5] = '{width_b, width_h, width_w, width_bu, width_hu};

    lsu_top #(.mm_reg_addr_bits(reg_bits)) dut0 (.*);

    lsu_checker #(.mm_reg_addr_bits(reg_bits)) chk0 (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ====================
    // responder models
    // ====================

    // byte enables land in the word arrays
    always @(negedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (mem_we[i]) begin
                mem_model[mem_addr[5:2]][8*i +: 8] = mem_wdata[8*i +: 8];
            end
            if (mm_reg_we[i]) begin
                reg_model[mm_reg_addr[3:0]][8*i +: 8] = mm_reg_wdata[8*i +: 8];
            end
        end
    end

    always begin : mem_responder
        int idx;
        int d;
        @(negedge clk);
        if (mem_re) begin
            idx = mem_addr[5:2];
            d   = resp_delay;
            @(posedge clk);
            repeat (d) @(posedge clk);
            #2;
            mem_valid = 1'b1;
            mem_rdata = mem_model[idx];
            @(posedge clk);
            #2;
            mem_valid = 1'b0;
        end
    end

    always begin : reg_responder
        int idx;
        int d;
        @(negedge clk);
        if (mm_reg_re) begin
            idx = mm_reg_addr[3:0];
            d   = resp_delay;
            @(posedge clk);
            repeat (d) @(posedge clk);
            #2;
            mm_reg_valid = 1'b1;
            mm_reg_rdata = reg_model[idx];
            @(posedge clk);
            #2;
            mm_reg_valid = 1'b0;
        end
    end

    // ====================
    // stimulus
    // ====================

    // one access, then wait for done or exception
    task automatic do_access(input logic is_store, input logic to_reg,
                             input ls_width_t w, input logic [1:0] off);
        logic [31:0] addr;
        logic        seen;
        int          waited;
        seed = lcg_next(seed);
        addr = {~to_reg, to_reg, seed[29:2], off};
        seed = lcg_next(seed);
        store_data = seed;
        seed = lcg_next(seed);
        rd_addr    = seed[20:16];
        resp_delay = seed[25:24];
        @(posedge clk);
        #2;
        width         = w;
        write_addr    = addr;
        read_addr     = addr;
        store_active  = is_store;
        load_active   = !is_store;
        access_enable = 1'b1;
        seen   = 1'b0;
        waited = 0;
        while (!seen && waited < wait_limit) begin
            #10;
            seen = store_done || load_done || exception_alignment;
            @(posedge clk);
            #2;
            access_enable = 1'b0;
            store_active  = 1'b0;
            load_active   = 1'b0;
            waited++;
        end
        if (!seen) begin
            timeout_count++;
            $display("timeout: access to %h got no done or exception within %0d cycles",
                     addr, wait_limit);
        end
    endtask

    initial begin
        ls_width_t w;
        seed          = 32'h49a2_787a;
        timeout_count = 0;
        resp_delay    = 0;
        reset_n       = 1'b0;
        access_enable = 1'b0;
        load_active   = 1'b0;
        store_active  = 1'b0;
        width         = width_b;
        write_addr    = '0;
        read_addr     = '0;
        store_data    = '0;
        rd_addr       = '0;
        mem_valid     = 1'b0;
        mem_rdata     = '0;
        mm_reg_valid  = 1'b0;
        mm_reg_rdata  = '0;
        for (int i = 0; i < 16; i++) begin
            mem_model[i] = (i * 32'h9e37_79b9) ^ 32'h1234_5678;
            reg_model[i] = ~(i * 32'h0f1e_2d3c);
        end
        repeat (8) @(posedge clk);
        #2;
        reset_n = 1'b1;
        // a few idle cycles for the post-reset check
        repeat (3) @(posedge clk);

        for (int k = 0; k < 2; k++) begin
            for (int sp = 0; sp < 2; sp++) begin
                for (int wi = 0; wi < 5; wi++) begin
                    for (int off = 0; off < 4; off++) begin
                        if (k == 1 && widths[wi][2]) begin
                            continue;
                        end
                        do_access(k == 1, sp == 1, widths[wi], off[1:0]);
                    end
                end
            end
        end

        for (int n = 0; n < random_accesses; n++) begin
            seed = lcg_next(seed);
            w = widths[seed[20:18] % 5];
            if (seed[16] && w[2]) begin
                w = ls_width_t'({1'b0, w[1:0]});
            end
            do_access(seed[16], seed[17], w, seed[22:21]);
        end

        repeat (4) @(posedge clk);
        $display("checks %0d, mismatches %0d, timeouts %0d",
                 check_count, mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0 && check_count > 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

// ==== verif/lsu_checker.sv ====
// Watches the load/store unit ports and predicts every strobe, store lane,
// address and load write-back from the access that started it.
// Counts checks and mismatches for the testbench's closing report.

module lsu_checker #(
    parameter int mm_reg_addr_bits = 8
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               access_enable,
    input  logic                               load_active,
    input  logic                               store_active,
    input  lsu_pkg::ls_width_t                 width,
    input  logic [lsu_pkg::xlen-1:0]           write_addr,
    input  logic [lsu_pkg::xlen-1:0]           read_addr,
    input  logic [lsu_pkg::xlen-1:0]           store_data,
    input  logic [lsu_pkg::reg_addr_bits-1:0]  rd_addr,
    input  logic                               mem_valid,
    input  logic [lsu_pkg::xlen-1:0]           mem_rdata,
    input  logic                               mm_reg_valid,
    input  logic [lsu_pkg::xlen-1:0]           mm_reg_rdata,
    input  logic                               mem_re,
    input  logic [lsu_pkg::xlen_bytes-1:0]     mem_we,
    input  logic [lsu_pkg::xlen-1:0]           mem_wdata,
    input  logic [lsu_pkg::xlen-1:0]           mem_addr,
    input  logic                               mm_reg_re,
    input  logic [lsu_pkg::xlen_bytes-1:0]     mm_reg_we,
    input  logic [lsu_pkg::xlen-1:0]           mm_reg_wdata,
    input  logic [mm_reg_addr_bits-1:0]        mm_reg_addr,
    input  logic                               store_done,
    input  logic                               load_done,
    input  logic                               exception_alignment,
    input  logic                               reg_we,
    input  logic [lsu_pkg::reg_addr_bits-1:0]  reg_addr,
    input  logic [lsu_pkg::xlen-1:0]           reg_wdata,
    output int                                 mismatch_count,
    output int                                 check_count
);

    import lsu_pkg::*;

    logic        start_store;
    logic        start_load;
    logic        store_bad;
    logic        load_bad;
    logic        finish;
    logic        store_pend;
    logic        store_to_mem;
    logic        load_fault_pend;
    logic        mm_re_pend;
    logic        load_wait;
    logic        load_from_mem;
    logic [3:0]  exp_lanes;
    logic [31:0] exp_wdata;
    logic [31:0] exp_addr;
    ls_width_t   ld_width;
    logic [1:0]  ld_off;
    logic [4:0]  ld_rd;
    string       cur_test;

    // ====================
    // reference functions
    // ====================
    function automatic logic bad_align(input ls_width_t w, input logic [1:0] off);
        if (w == width_w) begin
            return off != 2'd0;
        end
        if (w == width_h || w == width_hu) begin
            return off[0];
        end
        return 1'b0;
    endfunction

    function automatic logic [3:0] lanes(input ls_width_t w, input logic [1:0] off);
        logic [3:0] m;
        int nbytes;
        nbytes = (w == width_w) ? 4 : ((w == width_h || w == width_hu) ? 2 : 1);
        m = '0;
        for (int i = 0; i < nbytes; i++) begin
            if (off + i < 4) begin
                m[off + i] = 1'b1;
            end
        end
        return m;
    endfunction

    function automatic logic [31:0] load_value(input ls_width_t w, input logic [1:0] off,
                                               input logic [31:0] word);
        logic [31:0] v;
        v = word >> (8 * off);
        case (w)
            width_b:  return ({24'd0, v[7:0]} ^ 32'h80) - 32'h80;
            width_h:  return ({16'd0, v[15:0]} ^ 32'h8000) - 32'h8000;
            width_bu: return {24'd0, v[7:0]};
            width_hu: return {16'd0, v[15:0]};
            default:  return v;
        endcase
    endfunction

    function automatic logic [31:0] word_addr(input logic [31:0] addr);
        return (addr >> 2) & ((32'd1 << mm_reg_addr_bits) - 32'd1);
    endfunction

    task automatic compare(input string field, input logic [31:0] expected,
                           input logic [31:0] actual);
        check_count++;
        if (expected !== actual) begin
            mismatch_count++;
            $display("MISMATCH %s %s expected %h actual %h", cur_test, field, expected, actual);
        end
    endtask

    // ====================
    // per-cycle compare
    // ====================

    // mid-cycle sampling, inputs and flops are settled by then
    always @(negedge clk) begin
        if (!reset_n) begin
            store_pend      = 1'b0;
            load_fault_pend = 1'b0;
            mm_re_pend      = 1'b0;
            load_wait       = 1'b0;
            mismatch_count  = 0;
            check_count     = 0;
            cur_test        = "reset";
        end else begin
            start_store = access_enable && store_active;
            start_load  = access_enable && !store_active && load_active;
            store_bad   = start_store && bad_align(width, write_addr[1:0]);
            load_bad    = start_load && bad_align(width, read_addr[1:0]);
            finish      = load_wait && (mem_valid || mm_reg_valid);
            if (access_enable) begin
                cur_test = $sformatf("%s_%s_%s", store_active ? "store" : "load",
                    (store_active ? write_addr[30] : read_addr[30]) ? "reg" : "mem",
                    width.name());
            end

            compare("mem_we", (store_pend && store_to_mem) ? exp_lanes : 4'b0, mem_we);
            compare("mm_reg_we", (store_pend && !store_to_mem) ? exp_lanes : 4'b0, mm_reg_we);
            compare("store_done", store_pend, store_done);
            compare("exception_alignment", store_bad || load_fault_pend, exception_alignment);
            compare("mem_re", start_load && !load_bad && read_addr[31], mem_re);
            compare("mm_reg_re", mm_re_pend, mm_reg_re);
            compare("load_done", finish, load_done);
            compare("reg_we", finish, reg_we);

            if (store_pend && store_to_mem) begin
                compare("mem_wdata", exp_wdata, mem_wdata);
                compare("mem_addr", exp_addr, mem_addr);
            end
            if (store_pend && !store_to_mem) begin
                compare("mm_reg_wdata", exp_wdata, mm_reg_wdata);
                compare("mm_reg_addr", word_addr(exp_addr), mm_reg_addr);
            end
            if (mm_re_pend) begin
                compare("mm_reg_addr", word_addr(exp_addr), mm_reg_addr);
            end
            if (start_load && !load_bad && read_addr[31]) begin
                compare("mem_addr", read_addr, mem_addr);
            end
            if (finish) begin
                compare("reg_wdata", load_value(ld_width, ld_off,
                        load_from_mem ? mem_rdata : mm_reg_rdata), reg_wdata);
                compare("reg_addr", ld_rd, reg_addr);
                load_wait = 1'b0;
            end

            // expectations for the next cycle
            store_pend      = start_store && !store_bad;
            load_fault_pend = load_bad;
            mm_re_pend      = start_load && !load_bad && read_addr[30];
            if (store_pend) begin
                store_to_mem = write_addr[31];
                exp_lanes    = lanes(width, write_addr[1:0]);
                exp_wdata    = store_data << (8 * write_addr[1:0]);
                exp_addr     = write_addr;
            end
            if (start_load && !load_bad) begin
                load_wait     = 1'b1;
                load_from_mem = read_addr[31];
                ld_width      = width;
                ld_off        = read_addr[1:0];
                ld_rd         = rd_addr;
                exp_addr      = read_addr;
            end
        end
    end

endmodule

// ==== rtl/lsu_top.sv ====
// Top level of the load/store data-access unit.
// Connects the access state machine with the store and load data paths,
// forms the read strobes, the shared main-memory address and the
// register-space word address. mm_reg_addr_bits sets that address width.

module lsu_top #(
    parameter int mm_reg_addr_bits = 8
) (
    input  logic                               clk,
    input  logic                               reset_n,

    // access request
    input  logic                               access_enable,
    input  logic                               load_active,
    input  logic                               store_active,
    input  lsu_pkg::ls_width_t                 width,
    input  logic [lsu_pkg::xlen-1:0]           write_addr,
    input  logic [lsu_pkg::xlen-1:0]           read_addr,
    input  logic [lsu_pkg::xlen-1:0]           store_data,
    input  logic [lsu_pkg::reg_addr_bits-1:0]  rd_addr,

    // main memory
    input  logic                               mem_valid,
    input  logic [lsu_pkg::xlen-1:0]           mem_rdata,
    output logic                               mem_re,
    output logic [lsu_pkg::xlen_bytes-1:0]     mem_we,
    output logic [lsu_pkg::xlen-1:0]           mem_wdata,
    output logic [lsu_pkg::xlen-1:0]           mem_addr,

    // memory-mapped registers
    input  logic                               mm_reg_valid,
    input  logic [lsu_pkg::xlen-1:0]           mm_reg_rdata,
    output logic                               mm_reg_re,
    output logic [lsu_pkg::xlen_bytes-1:0]     mm_reg_we,
    output logic [lsu_pkg::xlen-1:0]           mm_reg_wdata,
    output logic [mm_reg_addr_bits-1:0]        mm_reg_addr,

    // status and write-back
    output logic                               store_done,
    output logic                               load_done,
    output logic                               exception_alignment,
    output logic                               reg_we,
    output logic [lsu_pkg::reg_addr_bits-1:0]  reg_addr,
    output logic [lsu_pkg::xlen-1:0]           reg_wdata
);

    import lsu_pkg::*;

    logic             store_go;
    logic             load_go;
    logic             load_finish;
    logic             store_fault;
    logic             load_fault_q;
    logic [xlen-1:0]  wdata;
    logic [xlen-1:0]  store_addr_q;
    logic             store_q;

    lsu_access_fsm u_fsm (
        .clk          (clk),
        .reset_n      (reset_n),
        .access_enable(access_enable),
        .load_active  (load_active),
        .store_active (store_active),
        .width        (width),
        .write_offset (write_addr[1:0]),
        .read_offset  (read_addr[1:0]),
        .mem_valid    (mem_valid),
        .mm_reg_valid (mm_reg_valid),
        .store_go     (store_go),
        .load_go      (load_go),
        .load_finish  (load_finish),
        .store_fault  (store_fault),
        .load_fault_q (load_fault_q)
    );

    lsu_store_path #(
        .mm_reg_addr_bits(mm_reg_addr_bits)
    ) u_store (
        .clk         (clk),
        .reset_n     (reset_n),
        .store_go    (store_go),
        .write_addr  (write_addr),
        .store_data  (store_data),
        .width       (width),
        .mem_we      (mem_we),
        .mm_reg_we   (mm_reg_we),
        .wdata       (wdata),
        .store_addr_q(store_addr_q),
        .store_q     (store_q),
        .store_done  (store_done)
    );

    lsu_load_path u_load (
        .clk         (clk),
        .reset_n     (reset_n),
        .load_go     (load_go),
        .load_finish (load_finish),
        .read_addr   (read_addr),
        .width       (width),
        .rd_addr     (rd_addr),
        .mem_valid   (mem_valid),
        .mem_rdata   (mem_rdata),
        .mm_reg_rdata(mm_reg_rdata),
        .reg_wdata   (reg_wdata),
        .reg_addr    (reg_addr)
    );

    // ====================
    // address and strobes
    // ====================

    // main memory reads start in the acceptance cycle
    assign mem_re = load_go & read_addr[mem_space_bit];

    // store address holds the bus for its enable cycle
    assign mem_addr = store_q ? store_addr_q : read_addr;

    assign mem_wdata    = wdata;
    assign mm_reg_wdata = wdata;

    // register space sees word addresses, one cycle late
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mm_reg_re   <= 1'b0;
            mm_reg_addr <= '0;
        end else begin
            mm_reg_re <= load_go & read_addr[reg_space_bit];
            if (store_go) begin
                mm_reg_addr <= write_addr[mm_reg_addr_bits+1:2];
            end else if (load_go) begin
                mm_reg_addr <= read_addr[mm_reg_addr_bits+1:2];
            end
        end
    end

    assign reg_we              = load_finish;
    assign load_done           = load_finish;
    assign exception_alignment = store_fault | load_fault_q;

endmodule

// ==== rtl/lsu_load_path.sv ====
// Load data path of the load/store unit.
// Captures width, byte offset and destination register when a load is
// accepted, then aligns and extends the response for register write-back.

module lsu_load_path (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               load_go,
    input  logic                               load_finish,
    input  logic [lsu_pkg::xlen-1:0]           read_addr,
    input  lsu_pkg::ls_width_t                 width,
    input  logic [lsu_pkg::reg_addr_bits-1:0]  rd_addr,
    input  logic                               mem_valid,
    input  logic [lsu_pkg::xlen-1:0]           mem_rdata,
    input  logic [lsu_pkg::xlen-1:0]           mm_reg_rdata,
    output logic [lsu_pkg::xlen-1:0]           reg_wdata,
    output logic [lsu_pkg::reg_addr_bits-1:0]  reg_addr
);

    import lsu_pkg::*;

    ls_width_t         width_q;
    logic [1:0]        offset_q;
    logic [xlen-1:0]   rdata;
    logic [xlen-1:0]   shifted;
    logic [xlen-1:0]   extended;

    // ====================
    // load context
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            width_q  <= width_w;
            offset_q <= 2'b00;
            reg_addr <= '0;
        end else if (load_go) begin
            width_q  <= width;
            offset_q <= read_addr[1:0];
            reg_addr <= rd_addr;
        end
    end

    // memory answers take the bus, otherwise the register space
    assign rdata   = mem_valid ? mem_rdata : mm_reg_rdata;
    assign shifted = rdata >> {offset_q, 3'b000};

    always_comb begin
        case (width_q)
            width_b:  extended = {{24{shifted[7]}}, shifted[7:0]};
            width_h:  extended = {{16{shifted[15]}}, shifted[15:0]};
            width_bu: extended = {24'd0, shifted[7:0]};
            width_hu: extended = {16'd0, shifted[15:0]};
            default:  extended = shifted;
        endcase
    end

    // quiet outside the write-back cycle
    assign reg_wdata = load_finish ? extended : '0;

endmodule

// ==== rtl/lsu_store_path.sv ====
// Store data path of the load/store unit.
// Shifts store data onto its byte lanes, builds the byte enables and
// registers them into the address space chosen by write_addr, one cycle
// after the store is accepted.

module lsu_store_path #(
    parameter int mm_reg_addr_bits = 8
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  logic                               store_go,
    input  logic [lsu_pkg::xlen-1:0]           write_addr,
    input  logic [lsu_pkg::xlen-1:0]           store_data,
    input  lsu_pkg::ls_width_t                 width,
    output logic [lsu_pkg::xlen_bytes-1:0]     mem_we,
    output logic [lsu_pkg::xlen_bytes-1:0]     mm_reg_we,
    output logic [lsu_pkg::xlen-1:0]           wdata,
    output logic [lsu_pkg::xlen-1:0]           store_addr_q,
    output logic                               store_q,
    output logic                               store_done
);

    import lsu_pkg::*;

    logic [xlen_bytes-1:0] base_mask;
    logic [xlen_bytes-1:0] lane_mask;

    // word address bits 2 and up must fit below the space-select bits
    if (mm_reg_addr_bits < 1 || mm_reg_addr_bits > 28) begin : g_bad_reg_addr_bits
        $error("mm_reg_addr_bits out of range 1 to 28");
    end

    // size mask before the lane shift
    always_comb begin
        case (width[1:0])
            2'b00:   base_mask = 4'b0001;
            2'b01:   base_mask = 4'b0011;
            default: base_mask = 4'b1111;
        endcase
    end

    assign lane_mask = base_mask << write_addr[1:0];

    // ====================
    // enables and done
    // ====================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            mem_we    <= '0;
            mm_reg_we <= '0;
            store_q   <= 1'b0;
        end else begin
            mem_we    <= (store_go && write_addr[mem_space_bit]) ? lane_mask : '0;
            mm_reg_we <= (store_go && write_addr[reg_space_bit]) ? lane_mask : '0;
            store_q   <= store_go;
        end
    end

    assign store_done = store_q;

    // data moved up by 8 times the byte offset
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wdata        <= '0;
            store_addr_q <= '0;
        end else if (store_go) begin
            wdata        <= store_data << {write_addr[1:0], 3'b000};
            store_addr_q <= write_addr;
        end
    end

    // the address map never selects both spaces for one store
    a_one_space: assert property (
        @(posedge clk) disable iff (!reset_n) !((|mem_we) && (|mm_reg_we)));

endmodule

// ==== rtl/lsu_access_fsm.sv ====
// Access control state machine of the load/store unit.
// Accepts one access per enable strobe, checks alignment from width and
// address offset, and waits in st_load until a read response arrives.
// Drives one-cycle strobes for the store and load data paths.

module lsu_access_fsm (
    input  logic                 clk,
    input  logic                 reset_n,
    input  logic                 access_enable,
    input  logic                 load_active,
    input  logic                 store_active,
    input  lsu_pkg::ls_width_t   width,
    input  logic [1:0]           write_offset,
    input  logic [1:0]           read_offset,
    input  logic                 mem_valid,
    input  logic                 mm_reg_valid,
    output logic                 store_go,
    output logic                 load_go,
    output logic                 load_finish,
    output logic                 store_fault,
    output logic                 load_fault_q
);

    import lsu_pkg::*;

    fsm_state_t state;
    fsm_state_t next_state;
    logic       store_misaligned;
    logic       load_misaligned;
    logic       load_fault;

    // halfwords need bit 0 clear, words need bits 1:0 clear
    function automatic logic misaligned(input ls_width_t w, input logic [1:0] offset);
        logic bad;
        case (w)
            width_h, width_hu: bad = offset[0];
            width_w:           bad = |offset;
            default:           bad = 1'b0;
        endcase
        return bad;
    endfunction

    assign store_misaligned = misaligned(width, write_offset);
    assign load_misaligned  = misaligned(width, read_offset);

    // ====================
    // next state
    // ====================
    always_comb begin
        next_state  = state;
        store_go    = 1'b0;
        load_go     = 1'b0;
        load_finish = 1'b0;
        store_fault = 1'b0;
        load_fault  = 1'b0;
        case (state)
            st_idle: begin
                // stores win when both kinds are flagged
                if (access_enable && store_active) begin
                    if (store_misaligned) begin
                        store_fault = 1'b1;
                        next_state  = st_exception;
                    end else begin
                        store_go = 1'b1;
                    end
                end else if (access_enable && load_active) begin
                    if (load_misaligned) begin
                        load_fault = 1'b1;
                        next_state = st_exception;
                    end else begin
                        load_go    = 1'b1;
                        next_state = st_load;
                    end
                end
            end
            st_exception: begin
                next_state = st_idle;
            end
            st_load: begin
                // no timeout, the responder sets the latency
                if (mem_valid || mm_reg_valid) begin
                    load_finish = 1'b1;
                    next_state  = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state        <= st_idle;
            load_fault_q <= 1'b0;
        end else begin
            state        <= next_state;
            load_fault_q <= load_fault;
        end
    end

    a_state_onehot: assert property (
        @(posedge clk) disable iff (!reset_n) $onehot(state));

    // the core may only start an access while the unit is idle
    a_enable_only_idle: assert property (
        @(posedge clk) disable iff (!reset_n) access_enable |-> state == st_idle);

endmodule

// ==== rtl/lsu_pkg.sv ====
// Shared constants and types for the load/store data-access unit.
// Every RTL file imports this package inside its module body and uses
// scoped names in its port list.

package lsu_pkg;

    // ====================
    // widths
    // ====================

    // data and address width, fixed since the lane shifts assume four bytes
    localparam int xlen = 32;

    // byte lanes per word, also the width of the byte enables
    localparam int xlen_bytes = xlen / 8;

    // register-file index width
    localparam int reg_addr_bits = 5;

    // ====================
    // address map
    // ====================

    // main memory when set
    localparam int mem_space_bit = 31;

    // memory-mapped register space when set
    localparam int reg_space_bit = 30;

    // ====================
    // types
    // ====================

    // access width, funct3 style encoding
    // bit 2 marks an unsigned load, bits 1:0 give the size
    typedef enum logic [2:0] {
        width_b  = 3'b000,
        width_h  = 3'b001,
        width_w  = 3'b010,
        width_bu = 3'b100,
        width_hu = 3'b101
    } ls_width_t;

    // access state machine, one-hot
    typedef enum logic [2:0] {
        st_idle      = 3'b001,
        st_exception = 3'b010,
        st_load      = 3'b100
    } fsm_state_t;

endpackage
